// ==== frame_cfg_pkg.sv ====
// Configuration package with the host status word layout and decoded field types
package frame_cfg_pkg;

    // Host status word and the 16-bit slices it is written in
    typedef logic [63:0] status_word_t;
    typedef logic [15:0] cfg_word_t;
    typedef logic [1:0]  cfg_addr_t;

    localparam int STATUS_WORDS = 4;

    // Decoded field types
    typedef logic [3:0]  offset_t;
    typedef logic [3:0]  hscale_t;
    typedef logic [2:0]  shadow_t;
    typedef logic [15:0] menumask_t;

    // Horizontal scaling for CRT
    localparam int HSIZE_EN_BIT    = 19;
    localparam int HSIZE_SCALE_LSB = 20;

    // Screen position
    localparam int HOFFSET_LSB = 24;
    localparam int VOFFSET_LSB = 28;

    // HDMI shadowmask overlay
    localparam int SHADOW_LSB     = 32;
    localparam int SHADOW_2X_BIT  = 35;
    localparam int SHADOW_ROT_BIT = 36;

    // User-port function enables
    localparam int DB15_EN_BIT = 37;
    localparam int UART_EN_BIT = 38;

    // Flip pair overlaps the UART enable bit
    localparam int         FLIP_LSB  = 38;
    localparam logic [1:0] FLIP_CODE = 2'd2;

    // Menu mask bits, a set bit hides the OSD item
    localparam int MENU_DIRECT_BIT = 0;
    localparam int MENU_VERT_BIT   = 1;
    localparam int MENU_HSIZE_BIT  = 2;
    localparam int MENU_SHADOW_BIT = 3;
    localparam int MENU_ROT_BIT    = 4;

endpackage

// ==== frame_bus_pkg.sv ====
// Bus package with DDR and user-port widths and the DDR arbiter state type
package frame_bus_pkg;

    // DDR command fields
    typedef logic [28:0] ddr_addr_t;
    typedef logic [7:0]  ddr_burst_t;
    typedef logic [7:0]  ddr_be_t;

    // Read beats in flight, room for several full bursts
    localparam int PEND_W = 12;
    typedef logic [PEND_W-1:0] pend_cnt_t;

    // Seven user-port pins
    typedef logic [6:0] user_pins_t;

    // Lines float high when nothing drives them
    localparam user_pins_t USER_IDLE = '1;

    // Serial pins of the user port
    localparam int UART_TX_PIN = 0;
    localparam int UART_RX_PIN = 1;

    // DDR ownership
    typedef enum logic [1:0] {
        ARB_LOAD  = 2'd0,
        ARB_ROT   = 2'd1,
        ARB_DRAIN = 2'd2
    } arb_state_t;

endpackage

// ==== frame_cfg_regs.sv ====
// Status word register written by the host controller, with OSD field decode
module frame_cfg_regs (
    input  logic                     clk_sys,
    input  logic                     rst,
    // Host word writes
    input  logic                     cfg_valid,
    input  frame_cfg_pkg::cfg_addr_t cfg_addr,
    input  frame_cfg_pkg::cfg_word_t cfg_data,
    output logic                     cfg_ready,
    // Core and video mode
    input  logic                     core_vertical,
    input  logic                     direct_video,
    // Decoded fields
    output frame_cfg_pkg::offset_t   hoffset,
    output frame_cfg_pkg::offset_t   voffset,
    output logic                     hsize_enable,
    output frame_cfg_pkg::hscale_t   hsize_scale,
    output frame_cfg_pkg::shadow_t   shadowmask,
    output logic                     shadowmask_2x,
    output logic                     shadowmask_rot,
    output logic                     uart_en,
    output logic                     db15_en,
    output logic                     framebuf_flip,
    output frame_cfg_pkg::menumask_t status_menumask
);
    import frame_cfg_pkg::*;

    localparam int SLICE_W = $bits(cfg_word_t);

    status_word_t status_q;
    status_word_t status_next;
    logic         cfg_write;

    // Writes accepted on any cycle outside reset
    assign cfg_ready = !rst;
    assign cfg_write = cfg_valid && cfg_ready;

    // Replace the addressed slice, keep the rest
    always_comb begin
        status_next = status_q;
        if (cfg_write) begin
            for (int i = 0; i < STATUS_WORDS; i++) begin
                if (cfg_addr == cfg_addr_t'(i)) begin
                    status_next[i*SLICE_W +: SLICE_W] = cfg_data;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            status_q      <= '0;
            framebuf_flip <= 1'b0;
        end else begin
            status_q      <= status_next;
            // Taken from the new word so flip moves with the other fields
            framebuf_flip <= status_next[FLIP_LSB +: 2] == FLIP_CODE;
        end
    end

    // Screen offsets and scaling
    assign hoffset      = status_q[HOFFSET_LSB +: $bits(offset_t)];
    assign voffset      = status_q[VOFFSET_LSB +: $bits(offset_t)];
    assign hsize_enable = status_q[HSIZE_EN_BIT];
    assign hsize_scale  = status_q[HSIZE_SCALE_LSB +: $bits(hscale_t)];

    // Shadowmask overlay
    assign shadowmask     = status_q[SHADOW_LSB +: $bits(shadow_t)];
    assign shadowmask_2x  = status_q[SHADOW_2X_BIT];
    assign shadowmask_rot = core_vertical ^ status_q[SHADOW_ROT_BIT];

    // User-port functions
    assign uart_en = status_q[UART_EN_BIT];
    assign db15_en = status_q[DB15_EN_BIT];

    // Hide menu items that do not apply to this core
    always_comb begin
        status_menumask                  = '0;
        status_menumask[MENU_DIRECT_BIT] = direct_video;
        status_menumask[MENU_VERT_BIT]   = !core_vertical;
        status_menumask[MENU_HSIZE_BIT]  = !hsize_enable;
        status_menumask[MENU_SHADOW_BIT] = shadowmask == '0;
        // No extra rotate options
        status_menumask[MENU_ROT_BIT]    = 1'b1;
    end

endmodule

// ==== frame_user_port.sv ====
// User-port pin synchroniser and registered joystick, UART or idle output select
module frame_user_port (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      uart_en,
    input  logic                      db15_en,
    input  frame_bus_pkg::user_pins_t user_in,
    // DB15 joystick pin pattern
    input  frame_bus_pkg::user_pins_t joy_pins,
    input  logic                      uart_tx,
    input  logic                      game_tx,
    output frame_bus_pkg::user_pins_t user_out,
    output logic                      game_rx,
    output frame_bus_pkg::user_pins_t user_sync
);
    import frame_bus_pkg::*;

    user_pins_t user_meta;
    user_pins_t out_next;

    // Two-flop synchroniser on the external pins
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            user_meta <= USER_IDLE;
            user_sync <= USER_IDLE;
        end else begin
            user_meta <= user_in;
            user_sync <= user_meta;
        end
    end

    // DB15 first, then UART, else lines left idle
    always_comb begin
        if (db15_en) begin
            out_next = joy_pins;
        end else if (uart_en) begin
            out_next              = '0;
            out_next[UART_RX_PIN] = 1'b1;
            // Cheat and core transmitters share the line
            out_next[UART_TX_PIN] = uart_tx & game_tx;
        end else begin
            out_next = USER_IDLE;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            user_out <= USER_IDLE;
        end else begin
            user_out <= out_next;
        end
    end

    // Receive line held at mark level while the UART is off
    assign game_rx = uart_en ? user_sync[UART_RX_PIN] : 1'b1;

endmodule

// ==== frame_ddr_arb.sv ====
// DDR port arbiter sharing one port between the ROM loader and the screen rotator
module frame_ddr_arb (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      downloading,
    // Fast ROM loader
    input  logic                      ld_rd,
    input  frame_bus_pkg::ddr_addr_t  ld_addr,
    input  frame_bus_pkg::ddr_burst_t ld_burstcnt,
    output logic                      ld_ready,
    // Screen rotator
    input  logic                      rot_rd,
    input  logic                      rot_we,
    input  frame_bus_pkg::ddr_addr_t  rot_addr,
    input  frame_bus_pkg::ddr_burst_t rot_burstcnt,
    input  frame_bus_pkg::ddr_be_t    rot_be,
    output logic                      rot_ready,
    // DDR port
    input  logic                      ddr_busy,
    input  logic                      ddr_dout_ready,
    output logic                      ddr_rd,
    output logic                      ddr_we,
    output frame_bus_pkg::ddr_addr_t  ddr_addr,
    output frame_bus_pkg::ddr_burst_t ddr_burstcnt,
    output frame_bus_pkg::ddr_be_t    ddr_be
);
    import frame_bus_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    pend_cnt_t  pend_cnt;
    pend_cnt_t  pend_next;
    logic       ld_owner;

    assign ld_owner = state == ARB_LOAD;

    // Owner must still match downloading, else a drain is about to start
    assign ld_ready  = ld_owner && downloading && !ddr_busy;
    assign rot_ready = (state == ARB_ROT) && !downloading && !ddr_busy;

    // Only accepted commands reach the port
    assign ddr_rd = (ld_rd && ld_ready) || (rot_rd && rot_ready);
    assign ddr_we = rot_we && rot_ready;

    // Payload follows the owner
    assign ddr_addr     = ld_owner ? ld_addr : rot_addr;
    assign ddr_burstcnt = ld_owner ? ld_burstcnt : rot_burstcnt;
    // Loader always writes whole words
    assign ddr_be       = ld_owner ? '1 : rot_be;

    // Read beats issued but not yet returned
    always_comb begin
        pend_next = pend_cnt;
        if (ddr_rd) begin
            pend_next = pend_next + pend_cnt_t'(ddr_burstcnt);
        end
        if (ddr_dout_ready) begin
            pend_next = pend_next - pend_cnt_t'(1);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ARB_LOAD: begin
                if (!downloading) begin
                    state_next = ARB_DRAIN;
                end
            end
            ARB_ROT: begin
                if (downloading) begin
                    state_next = ARB_DRAIN;
                end
            end
            ARB_DRAIN: begin
                // Hand over once the last beat is back
                if (pend_cnt == '0) begin
                    state_next = downloading ? ARB_LOAD : ARB_ROT;
                end
            end
            default: begin
                state_next = ARB_ROT;
            end
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state    <= ARB_ROT;
            pend_cnt <= '0;
        end else begin
            state    <= state_next;
            pend_cnt <= pend_next;
        end
    end

endmodule

// ==== frame_shell_top.sv ====
// Board shell top level with configuration, user-port and DDR arbitration blocks
module frame_shell_top (
    input  logic                      clk_sys,
    input  logic                      rst,
    // Host configuration writes
    input  logic                      cfg_valid,
    input  frame_cfg_pkg::cfg_addr_t  cfg_addr,
    input  frame_cfg_pkg::cfg_word_t  cfg_data,
    output logic                      cfg_ready,
    input  logic                      core_vertical,
    input  logic                      direct_video,
    // Decoded configuration
    output frame_cfg_pkg::offset_t    hoffset,
    output frame_cfg_pkg::offset_t    voffset,
    output logic                      hsize_enable,
    output frame_cfg_pkg::hscale_t    hsize_scale,
    output frame_cfg_pkg::shadow_t    shadowmask,
    output logic                      shadowmask_2x,
    output logic                      shadowmask_rot,
    output logic                      framebuf_flip,
    output frame_cfg_pkg::menumask_t  status_menumask,
    output logic                      uart_en,
    output logic                      db15_en,
    // User port
    input  frame_bus_pkg::user_pins_t user_in,
    input  frame_bus_pkg::user_pins_t joy_pins,
    input  logic                      uart_tx,
    input  logic                      game_tx,
    output frame_bus_pkg::user_pins_t user_out,
    output logic                      game_rx,
    output frame_bus_pkg::user_pins_t user_sync,
    // DDR requesters
    input  logic                      downloading,
    input  logic                      ld_rd,
    input  frame_bus_pkg::ddr_addr_t  ld_addr,
    input  frame_bus_pkg::ddr_burst_t ld_burstcnt,
    output logic                      ld_ready,
    input  logic                      rot_rd,
    input  logic                      rot_we,
    input  frame_bus_pkg::ddr_addr_t  rot_addr,
    input  frame_bus_pkg::ddr_burst_t rot_burstcnt,
    input  frame_bus_pkg::ddr_be_t    rot_be,
    output logic                      rot_ready,
    // DDR port
    input  logic                      ddr_busy,
    input  logic                      ddr_dout_ready,
    output logic                      ddr_rd,
    output logic                      ddr_we,
    output frame_bus_pkg::ddr_addr_t  ddr_addr,
    output frame_bus_pkg::ddr_burst_t ddr_burstcnt,
    output frame_bus_pkg::ddr_be_t    ddr_be
);

    // Status word, its decode and the enables that steer the user port
    frame_cfg_regs u_cfg_regs (.*);

    // Joystick, UART or idle levels on the user pins
    frame_user_port u_user_port (.*);

    // Loader during downloads, rotator the rest of the time
    frame_ddr_arb u_ddr_arb (.*);

endmodule

// ==== frame_shell_asserts.sv ====
// Concurrent checks on the DDR arbiter readies and the commands it forwards
module frame_ddr_arb_asserts (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      ld_ready,
    input  logic                      rot_ready,
    input  logic                      ddr_busy,
    input  logic                      ddr_rd,
    input  logic                      ddr_we,
    input  frame_bus_pkg::arb_state_t state
);
    import frame_bus_pkg::*;

    // Read by the testbench when it sums up the run
    int assert_failures = 0;

    // One owner at a time
    ready_exclusive: assert property (@(posedge clk_sys) disable iff (rst)
        !(ld_ready && rot_ready))
        else begin
            $error("ld_ready and rot_ready are high in the same cycle");
            assert_failures++;
        end

    no_ready_in_drain: assert property (@(posedge clk_sys) disable iff (rst)
        state == ARB_DRAIN |-> !ld_ready && !rot_ready)
        else begin
            $error("a ready is high while the arbiter drains");
            assert_failures++;
        end

    // Commands only reach an idle DDR port
    no_cmd_when_busy: assert property (@(posedge clk_sys) disable iff (rst)
        ddr_busy |-> !ddr_rd && !ddr_we)
        else begin
            $error("DDR command issued while ddr_busy is high");
            assert_failures++;
        end

endmodule

bind frame_ddr_arb frame_ddr_arb_asserts frame_ddr_arb_asserts_inst (.*);

// ==== frame_shell_tb.sv ====
// Data-driven testbench for the board shell, with a random DDR port model
module frame_shell_tb;
    import frame_cfg_pkg::*;
    import frame_bus_pkg::*;

    localparam string DATA_FILE = "frame_shell_testdata.txt";

    logic       clk_sys;
    logic       rst;
    logic       cfg_valid;
    logic       cfg_ready;
    cfg_addr_t  cfg_addr;
    cfg_word_t  cfg_data;
    logic       core_vertical;
    logic       direct_video;
    offset_t    hoffset;
    offset_t    voffset;
    hscale_t    hsize_scale;
    shadow_t    shadowmask;
    menumask_t  status_menumask;
    logic       hsize_enable, shadowmask_2x, shadowmask_rot, framebuf_flip;
    logic       uart_en, db15_en, uart_tx, game_tx, game_rx;
    user_pins_t user_in, joy_pins, user_out, user_sync;
    logic       downloading, ld_rd, ld_ready, rot_rd, rot_we, rot_ready;
    ddr_addr_t  ld_addr, rot_addr, ddr_addr;
    ddr_burst_t ld_burstcnt, rot_burstcnt, ddr_burstcnt;
    ddr_be_t    rot_be, ddr_be;
    logic       ddr_busy, ddr_dout_ready, ddr_rd, ddr_we;

    // Status word as written by the accepted slices
    status_word_t status_model;

    // One entry per data record
    string       rec_name[$];
    string       rec_op[$];
    logic [31:0] rec_a[$];
    logic [31:0] rec_b[$];
    logic [31:0] rec_c[$];
    logic [31:0] rec_exp[$];

    integer seed = 32'h3fac;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    int     beats_issued = 0;
    int     beats_returned = 0;

    frame_shell_top frame_shell_top_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever begin
            #5 clk_sys = ~clk_sys;
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d errors: %0d", checks, errors);
            $display("Verification failed");
            $finish;
        end
    end

    // DDR model with random busy and read beats returned some cycles later
    always @(posedge clk_sys) begin
        if (rst) begin
            ddr_busy       <= 1'b0;
            ddr_dout_ready <= 1'b0;
        end else begin
            if (ddr_rd && !ddr_busy) begin
                beats_issued += ddr_burstcnt;
            end
            if (ddr_dout_ready) begin
                beats_returned++;
            end
            ddr_busy       <= ($random(seed) & 3) == 0;
            ddr_dout_ready <= (beats_issued > beats_returned) && (($random(seed) & 1) != 0);
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Field codes as listed in the data file
    function automatic logic [31:0] read_field(input logic [31:0] sel);
        logic [31:0] value;
        case (sel)
            0:  value = 32'(hoffset);
            1:  value = 32'(voffset);
            2:  value = 32'(hsize_enable);
            3:  value = 32'(hsize_scale);
            4:  value = 32'(shadowmask);
            5:  value = 32'(shadowmask_2x);
            6:  value = 32'(shadowmask_rot);
            7:  value = 32'(uart_en);
            8:  value = 32'(db15_en);
            9:  value = 32'(framebuf_flip);
            10: value = 32'(status_menumask);
            11: value = 32'(cfg_ready);
            12: value = 32'(user_out);
            default: value = 'x;
        endcase
        return value;
    endfunction

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        string       name;
        string       op;
        logic [31:0] a, b, c, e;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", DATA_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, e);
            if (n == 6) begin
                rec_name.push_back(name);
                rec_op.push_back(op);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
                rec_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic write_slice(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_sys);
        cfg_valid <= 1'b1;
        cfg_addr  <= cfg_addr_t'(addr);
        cfg_data  <= cfg_word_t'(data);
        @(negedge clk_sys);
        while (!cfg_ready) begin
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
        cfg_valid <= 1'b0;
    endtask

    // Owner requests at addr while the other requester competes with inverted fields
    task automatic issue_command(input string name, input logic loader, input logic write,
                                 input logic [31:0] addr, input logic [31:0] burst,
                                 input logic [31:0] be, input logic [31:0] exp_be);
        @(posedge clk_sys);
        ld_rd        <= 1'b1;
        ld_addr      <= ddr_addr_t'(loader ? addr : ~addr);
        ld_burstcnt  <= ddr_burst_t'(loader ? burst : ~burst);
        rot_rd       <= !loader && !write;
        rot_we       <= loader || write;
        rot_addr     <= ddr_addr_t'(loader ? ~addr : addr);
        rot_burstcnt <= ddr_burst_t'(loader ? ~burst : burst);
        rot_be       <= ddr_be_t'(be);
        @(negedge clk_sys);
        while (!(loader ? ld_ready : rot_ready)) begin
            @(negedge clk_sys);
        end
        check_value(name, 32'd0, 32'(loader ? rot_ready : ld_ready));
        check_value(name, {30'd0, !write, write}, {30'd0, ddr_rd, ddr_we});
        check_value(name, 32'(ddr_addr_t'(addr)), 32'(ddr_addr));
        check_value(name, 32'(ddr_burst_t'(burst)), 32'(ddr_burstcnt));
        check_value(name, exp_be, 32'(ddr_be));
        @(posedge clk_sys);
        ld_rd  <= 1'b0;
        rot_rd <= 1'b0;
        rot_we <= 1'b0;
    endtask

    task automatic run_record(input int idx);
        string       name;
        logic [31:0] a, b, c, e;
        name = rec_name[idx];
        a = rec_a[idx];
        b = rec_b[idx];
        c = rec_c[idx];
        e = rec_exp[idx];
        case (rec_op[idx])
            "rstw": begin
                @(posedge clk_sys);
                rst       <= 1'b1;
                cfg_valid <= 1'b1;
                cfg_addr  <= cfg_addr_t'(a);
                cfg_data  <= cfg_word_t'(b);
                status_model = '0;
                @(negedge clk_sys);
                check_value(name, e, 32'(cfg_ready));
                repeat (3) @(posedge clk_sys);
                rst       <= 1'b0;
                cfg_valid <= 1'b0;
            end
            "wr": begin
                write_slice(a, b);
                status_model[a[1:0] * $bits(cfg_word_t) +: $bits(cfg_word_t)] = cfg_word_t'(b);
                @(negedge clk_sys);
                check_value(name, 32'(status_model[SHADOW_2X_BIT]), 32'(shadowmask_2x));
                check_value(name, 32'(status_model[DB15_EN_BIT]), 32'(db15_en));
            end
            "mode": begin
                @(posedge clk_sys);
                core_vertical <= a[0];
                direct_video  <= b[0];
            end
            "fld": begin
                @(negedge clk_sys);
                check_value(name, e, read_field(a));
            end
            "upin": begin
                @(posedge clk_sys);
                user_in  <= user_pins_t'(a);
                joy_pins <= user_pins_t'(b);
                uart_tx  <= c[1];
                game_tx  <= c[0];
                @(posedge clk_sys);
                @(negedge clk_sys);
                check_value(name, e, 32'(user_out));
            end
            "rx": begin
                @(posedge clk_sys);
                user_in <= user_pins_t'(a);
                @(posedge clk_sys);
                @(negedge clk_sys);
                // Still the old pin after one cycle
                check_value(name, b, 32'(game_rx));
                @(negedge clk_sys);
                check_value(name, e, 32'(game_rx));
                check_value(name, 32'(user_pins_t'(a)), 32'(user_sync));
            end
            "dl": begin
                @(posedge clk_sys);
                downloading <= a[0];
                @(negedge clk_sys);
                while (!(a[0] ? ld_ready : rot_ready)) begin
                    @(negedge clk_sys);
                end
                // New owner only after every issued beat is back
                check_value(name, e, 32'(beats_issued - beats_returned));
            end
            "ld":  issue_command(name, 1'b1, 1'b0, a, b, c, e);
            "rrd": issue_command(name, 1'b0, 1'b0, a, b, c, e);
            "rwr": issue_command(name, 1'b0, 1'b1, a, b, c, e);
            "cnt": begin
                @(negedge clk_sys);
                while (beats_returned != beats_issued) begin
                    @(negedge clk_sys);
                end
                check_value(name, e, 32'(beats_issued));
            end
            default: begin
                $display("unknown operation %s in record %s", rec_op[idx], name);
                errors++;
            end
        endcase
    endtask

    initial begin
        rst            = 1'b1;
        cfg_valid      = 1'b0;
        cfg_addr       = '0;
        cfg_data       = '0;
        core_vertical  = 1'b0;
        direct_video   = 1'b0;
        user_in        = USER_IDLE;
        joy_pins       = '0;
        uart_tx        = 1'b1;
        game_tx        = 1'b1;
        downloading    = 1'b0;
        ld_rd          = 1'b0;
        ld_addr        = '0;
        ld_burstcnt    = '0;
        rot_rd         = 1'b0;
        rot_we         = 1'b0;
        rot_addr       = '0;
        rot_burstcnt   = '0;
        rot_be         = '0;
        ddr_busy       = 1'b0;
        ddr_dout_ready = 1'b0;
        status_model   = '0;
        load_records();
        cycle_limit = 40 * rec_name.size() + 200;
        repeat (3) @(posedge clk_sys);
        rst <= 1'b0;
        foreach (rec_name[i]) begin
            run_record(i);
        end
        repeat (2) @(posedge clk_sys);
        errors += frame_shell_top_inst.u_ddr_arb.frame_ddr_arb_asserts_inst.assert_failures;
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== frame_shell.f ====
frame_cfg_pkg.sv
frame_bus_pkg.sv
frame_cfg_regs.sv
frame_user_port.sv
frame_ddr_arb.sv
frame_shell_top.sv
frame_shell_asserts.sv
frame_shell_tb.sv

// ==== frame_shell_testdata.txt ====
# name op a b c expected, all numbers hex; ops rstw wr mode fld upin rx dl ld rrd rwr cnt
# fld codes: 0 hoff 1 voff 2 hsize_en 3 hscale 4 shadow 5 2x 6 rot 7 uart 8 db15 9 flip a menu b ready c user_out
reset_write rstw 1 ffff 0 0
reset_fields fld a 0 0 1e
reset_fields fld c 0 0 7f
status_write wr 0 1234 0 0
status_write wr 1 a5b8 0 0
status_write wr 2 0016 0 0
status_write wr 3 ffff 0 0
status_decode fld 0 0 0 5
status_decode fld 1 0 0 a
status_decode fld 2 0 0 1
status_decode fld 3 0 0 b
status_decode fld 4 0 0 6
derived_fields fld 6 0 0 1
derived_fields fld a 0 0 12
derived_fields mode 1 1 0 0
derived_fields fld 6 0 0 0
derived_fields fld a 0 0 11
derived_fields wr 2 0080 0 0
derived_fields fld 9 0 0 1
derived_fields fld a 0 0 19
derived_fields wr 2 00c0 0 0
derived_fields fld 9 0 0 0
derived_fields fld 7 0 0 1
user_idle wr 2 0000 0 0
user_idle upin 55 2a 3 7f
user_uart wr 2 0040 0 0
user_uart upin 55 2a 3 3
user_rx rx 2 0 0 1
user_rx rx 7d 1 0 0
user_db15 wr 2 0060 0 0
user_db15 upin 55 2a 3 2a
user_rx_off wr 2 0000 0 0
user_rx_off rx 2 1 0 1
ddr_own dl 1 0 0 0
ddr_load ld 1000 8 0 ff
ddr_load ld 1fffffff 2 0 ff
ddr_drain dl 0 0 0 0
ddr_rot rrd 200 4 0f 0f
ddr_rot rwr 300 1 a5 a5
ddr_rot rrd 400 6 ff ff
ddr_drain dl 1 0 0 0
ddr_load ld 2000 3 0 ff
ddr_drain dl 0 0 0 0
ddr_beats cnt 0 0 0 17
